//--- source/core_pkg.sv
package core_pkg;

	// RV64I integer width
	localparam int XLEN = 64;

	// Architectural registers only
	// x0 is hardwired, x1..x31 are real storage
	localparam int NUM_XREG = 32;

	// Index width follows the register count
	localparam int REG_IDX_W = $clog2(NUM_XREG);

	// One register value
	typedef logic [XLEN-1:0] xdata_t;

	// Register number as it appears in an instruction
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

//--- source/lsu_pkg.sv
package lsu_pkg;
	import core_pkg::*;

	// Load buffer slots
	localparam int LU_DEPTH = 4;

	// Store queue entries, power of two so pointers wrap by themselves
	localparam int SU_DEPTH = 4;

	// Slot number inside the load buffer
	typedef logic [$clog2(LU_DEPTH)-1:0] lu_slot_t;

	// Store queue pointer and fill count
	typedef logic [$clog2(SU_DEPTH)-1:0] su_ptr_t;
	typedef logic [$clog2(SU_DEPTH+1)-1:0] su_cnt_t;

	// Dispatched load, MSB first
	// {lb, lh, lw, ld, lbu, lhu, lwu, imm[63:0], rd, rs1}
	localparam int LU_FLAG_W = 7;
	localparam int LU_INFO_W = LU_FLAG_W + XLEN + 2 * REG_IDX_W;

	// rd sits just above rs1
	localparam int LU_RD_LSB = REG_IDX_W;

	typedef logic [LU_INFO_W-1:0] lu_info_t;

	// Dispatched store, MSB first
	// {sb, sh, sw, sd, imm[63:0], rs1, rs2}
	localparam int SU_FLAG_W = 4;
	localparam int SU_INFO_W = SU_FLAG_W + XLEN + 2 * REG_IDX_W;

	typedef logic [SU_INFO_W-1:0] su_info_t;

	// Load execute parameter, MSB first
	// {fun_b, fun_h, fun_w, fun_d, rd, addr[63:0], is_unsigned}
	// Signed and unsigned flavours share one function bit
	localparam int LU_FUN_W = 4;
	localparam int LU_EXE_W = LU_FUN_W + REG_IDX_W + XLEN + 1;

	typedef logic [LU_EXE_W-1:0] lu_exeparam_t;

	// Store execute parameter, MSB first
	// {sb, sh, sw, sd, addr[63:0], data[63:0]}
	localparam int SU_EXE_W = SU_FLAG_W + 2 * XLEN;

	typedef logic [SU_EXE_W-1:0] su_exeparam_t;

endpackage

//--- source/first_zero_finder.sv
module first_zero_finder import lsu_pkg::*; #(
	// Any power of two, pos_t must hold log2(WIDTH) bits
	parameter int WIDTH = LU_DEPTH,
	parameter type pos_t = lu_slot_t
) (
	input  logic [WIDTH-1:0] in_bits,
	output pos_t             pos,
	output logic             all_ones
);

	// Walk from the top down so the lowest zero is written last
	always_comb begin
		pos = '0;
		for (int i = WIDTH - 1; i >= 0; i--) begin
			if (!in_bits[i]) begin
				pos = pos_t'(i);
			end
		end
	end

	// No zero anywhere, pos is then meaningless
	assign all_ones = &in_bits;

endmodule

//--- source/regfile_wblog.sv
module regfile_wblog import core_pkg::*; (
	input  logic                CLK,
	input  logic                rst_n,
	// Accepted load marks its rd busy
	input  logic                busy_strobe,
	input  reg_idx_t            busy_rd,
	// Result writeback
	input  logic                wb_strobe,
	input  reg_idx_t            wb_rd,
	input  xdata_t              wb_data,
	output xdata_t              xreg_value [NUM_XREG],
	output logic [NUM_XREG-1:0] wb_log
);

	// Storage for x1..x31 only
	xdata_t xreg_q [1:NUM_XREG-1];

	// Writeback log where 1 means the value is current
	logic [NUM_XREG-1:1] ready_q;

	// Decode per register so x0 never gets a select
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < NUM_XREG; i++) begin
				xreg_q[i] <= '0;
			end
			ready_q <= '1;
		end else begin
			for (int i = 1; i < NUM_XREG; i++) begin
				if (busy_strobe && busy_rd == reg_idx_t'(i)) begin
					ready_q[i] <= 1'b0;
				end
				// Writeback last so it wins a same-cycle busy
				if (wb_strobe && wb_rd == reg_idx_t'(i)) begin
					ready_q[i] <= 1'b1;
					xreg_q[i] <= wb_data;
				end
			end
		end
	end

	// x0 reads zero
	assign xreg_value[0] = '0;

	for (genvar i = 1; i < NUM_XREG; i++) begin : gen_xreg_out
		assign xreg_value[i] = xreg_q[i];
	end

	// x0 is always ready
	assign wb_log = {ready_q, 1'b1};

	// Busy marking or writeback aimed only at x0 leaves the log alone
	x0_write_ignored_a: assert property (@(posedge CLK) disable iff (!rst_n)
		(!wb_strobe || wb_rd == '0) && (!busy_strobe || busy_rd == '0)
		|=> $stable(wb_log));

endmodule

//--- source/lu_issue_buffer.sv
module lu_issue_buffer import lsu_pkg::*; (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                dispatch_strobe,
	input  lu_info_t            dispatch_info,
	// Issue stage takes one slot per cycle
	input  logic                pop,
	input  lu_slot_t            pop_slot,
	output logic [LU_DEPTH-1:0] alloc,
	output lu_info_t            slot_info [LU_DEPTH],
	output logic                full
);

	lu_slot_t free_slot;
	logic     dispatch_ok;

	// Lowest unallocated slot, all allocated means full
	first_zero_finder #(
		.WIDTH (LU_DEPTH),
		.pos_t (lu_slot_t)
	) u_free_pick (
		.in_bits  (alloc),
		.pos      (free_slot),
		.all_ones (full)
	);

	// Strobe while full is dropped
	assign dispatch_ok = dispatch_strobe & ~full;

	// Allocation bits
	// Pop hits an occupied slot, dispatch a free one, never the same
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			alloc <= '0;
		end else begin
			if (pop) begin
				alloc[pop_slot] <= 1'b0;
			end
			if (dispatch_ok) begin
				alloc[free_slot] <= 1'b1;
			end
		end
	end

	// Slot payload, only meaningful under its alloc bit
	always_ff @(posedge CLK) begin
		if (dispatch_ok) begin
			slot_info[free_slot] <= dispatch_info;
		end
	end

	// Issue stage may only select occupied slots
	pop_alloc_a: assert property (@(posedge CLK) disable iff (!rst_n)
		pop |-> alloc[pop_slot]);

endmodule

//--- source/su_issue_fifo.sv
module su_issue_fifo import lsu_pkg::*; (
	input  logic     CLK,
	input  logic     rst_n,
	input  logic     push,
	input  su_info_t push_info,
	input  logic     pop,
	// Oldest store, valid while not empty
	output su_info_t head_info,
	output logic     empty,
	output logic     full
);

	su_info_t mem [SU_DEPTH];
	su_ptr_t  rd_ptr;
	su_ptr_t  wr_ptr;
	su_cnt_t  count;
	logic     push_ok;
	logic     pop_ok;

	assign push_ok = push & ~full;
	assign pop_ok  = pop & ~empty;

	// Pointers and fill level
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave count alone
			if (push_ok && !pop_ok) begin
				count <= count + 1'b1;
			end else if (pop_ok && !push_ok) begin
				count <= count - 1'b1;
			end
		end
	end

	// Entry storage
	always_ff @(posedge CLK) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_info;
		end
	end

	assign head_info = mem[rd_ptr];
	assign empty     = (count == '0);
	assign full      = (count == su_cnt_t'(SU_DEPTH));

	// Dispatch side must respect full
	no_overflow_a: assert property (@(posedge CLK) disable iff (!rst_n)
		push |-> !full);

	// Issue stage only pops a present head
	no_underflow_a: assert property (@(posedge CLK) disable iff (!rst_n)
		pop |-> !empty);

endmodule

//--- source/lsu_issue.sv
module lsu_issue import core_pkg::*, lsu_pkg::*; (
	input  logic                CLK,
	input  logic                rst_n,
	// Load buffer side
	input  logic [LU_DEPTH-1:0] lu_alloc,
	input  lu_info_t            lu_slot_info [LU_DEPTH],
	output logic                lu_pop,
	output lu_slot_t            lu_pop_slot,
	// Load execute output
	input  logic                lu_exe_ready,
	output logic                lu_exe_valid,
	output lu_exeparam_t        lu_exe_param,
	// Store queue side
	input  su_info_t            su_head_info,
	input  logic                su_empty,
	output logic                su_pop,
	// Commit allows the head store to go
	input  logic                su_commit_ready,
	// Store execute output
	input  logic                su_exe_ready,
	output logic                su_exe_valid,
	output su_exeparam_t        su_exe_param,
	// Register state
	input  xdata_t              xreg_value [NUM_XREG],
	input  logic [NUM_XREG-1:0] wb_log
);

	logic [LU_DEPTH-1:0] lu_eligible;
	lu_exeparam_t        lu_slot_param [LU_DEPTH];
	lu_slot_t            lu_sel;
	logic                lu_none;

	logic                su_sb;
	logic                su_sh;
	logic                su_sw;
	logic                su_sd;
	xdata_t              su_imm;
	reg_idx_t            su_rs1;
	reg_idx_t            su_rs2;
	logic                su_eligible;
	su_exeparam_t        su_param_d;

	// Loads, every slot evaluated in parallel
	for (genvar i = 0; i < LU_DEPTH; i++) begin : gen_lu_slot
		logic     lb;
		logic     lh;
		logic     lw;
		logic     ld;
		logic     lbu;
		logic     lhu;
		logic     lwu;
		xdata_t   imm;
		reg_idx_t rd;
		reg_idx_t rs1;

		assign {lb, lh, lw, ld, lbu, lhu, lwu, imm, rd, rs1} = lu_slot_info[i];

		// RAW clear once base is written back, x0 always clear
		assign lu_eligible[i] = lu_alloc[i] & wb_log[rs1];

		// Width one-hot merged, signedness kept in the low bit
		assign lu_slot_param[i] = {
			lb | lbu,
			lh | lhu,
			lw | lwu,
			ld,
			rd,
			xreg_value[rs1] + imm,
			lbu | lhu | lwu
		};
	end

	// Lowest eligible slot wins, older ones may be overtaken
	first_zero_finder #(
		.WIDTH (LU_DEPTH),
		.pos_t (lu_slot_t)
	) u_lu_pick (
		.in_bits  (~lu_eligible),
		.pos      (lu_sel),
		.all_ones (lu_none)
	);

	// Pop only when the output register takes the entry
	assign lu_pop      = lu_exe_ready & ~lu_none;
	assign lu_pop_slot = lu_sel;

	// Valid follows eligibility while ready, holds otherwise
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			lu_exe_valid <= 1'b0;
		end else if (lu_exe_ready) begin
			lu_exe_valid <= ~lu_none;
		end
	end

	always_ff @(posedge CLK) begin
		if (lu_pop) begin
			lu_exe_param <= lu_slot_param[lu_sel];
		end
	end

	// Stores, head only, strictly in order
	assign {su_sb, su_sh, su_sw, su_sd, su_imm, su_rs1, su_rs2} = su_head_info;

	// Both sources written back and commit says go
	assign su_eligible = ~su_empty & wb_log[su_rs1] & wb_log[su_rs2] & su_commit_ready;

	// Address from rs1, data straight from rs2
	assign su_param_d = {
		su_sb,
		su_sh,
		su_sw,
		su_sd,
		xreg_value[su_rs1] + su_imm,
		xreg_value[su_rs2]
	};

	assign su_pop = su_exe_ready & su_eligible;

	// Same output rule as loads
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			su_exe_valid <= 1'b0;
		end else if (su_exe_ready) begin
			su_exe_valid <= su_eligible;
		end
	end

	always_ff @(posedge CLK) begin
		if (su_pop) begin
			su_exe_param <= su_param_d;
		end
	end

	// Stalled outputs stay frozen for the consumer
	lu_hold_a: assert property (@(posedge CLK) disable iff (!rst_n)
		lu_exe_valid && !lu_exe_ready |=> lu_exe_valid && $stable(lu_exe_param));

	su_hold_a: assert property (@(posedge CLK) disable iff (!rst_n)
		su_exe_valid && !su_exe_ready |=> su_exe_valid && $stable(su_exe_param));

endmodule

//--- source/lsu_issue_top.sv
module lsu_issue_top import core_pkg::*, lsu_pkg::*; (
	input  logic         CLK,
	input  logic         rst_n,
	// Load dispatch
	input  logic         lu_dispatch_strobe,
	input  lu_info_t     lu_dispatch_info,
	output logic         lu_buffer_full,
	// Store dispatch
	input  logic         su_dispatch_strobe,
	input  su_info_t     su_dispatch_info,
	output logic         su_fifo_full,
	// Writeback
	input  logic         wb_strobe,
	input  reg_idx_t     wb_rd,
	input  xdata_t       wb_data,
	// Commit permission for stores
	input  logic         su_commit_ready,
	// Execute outputs
	input  logic         lu_exe_ready,
	output logic         lu_exe_valid,
	output lu_exeparam_t lu_exe_param,
	input  logic         su_exe_ready,
	output logic         su_exe_valid,
	output su_exeparam_t su_exe_param
);

	logic                lu_accept;
	logic                su_accept;
	reg_idx_t            lu_dispatch_rd;
	logic [LU_DEPTH-1:0] lu_alloc;
	lu_info_t            lu_slot_info [LU_DEPTH];
	logic                lu_pop;
	lu_slot_t            lu_pop_slot;
	su_info_t            su_head_info;
	logic                su_empty;
	logic                su_pop;
	xdata_t              xreg_value [NUM_XREG];
	logic [NUM_XREG-1:0] wb_log;

	// Dispatch is dropped while the target is full
	assign lu_accept = lu_dispatch_strobe & ~lu_buffer_full;
	assign su_accept = su_dispatch_strobe & ~su_fifo_full;

	// Destination of the incoming load goes busy
	assign lu_dispatch_rd = lu_dispatch_info[LU_RD_LSB +: REG_IDX_W];

	regfile_wblog u_regfile (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.busy_strobe (lu_accept),
		.busy_rd     (lu_dispatch_rd),
		.wb_strobe   (wb_strobe),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.xreg_value  (xreg_value),
		.wb_log      (wb_log)
	);

	lu_issue_buffer u_lu_buffer (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.dispatch_strobe (lu_accept),
		.dispatch_info   (lu_dispatch_info),
		.pop             (lu_pop),
		.pop_slot        (lu_pop_slot),
		.alloc           (lu_alloc),
		.slot_info       (lu_slot_info),
		.full            (lu_buffer_full)
	);

	su_issue_fifo u_su_fifo (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.push      (su_accept),
		.push_info (su_dispatch_info),
		.pop       (su_pop),
		.head_info (su_head_info),
		.empty     (su_empty),
		.full      (su_fifo_full)
	);

	lsu_issue u_issue (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.lu_alloc        (lu_alloc),
		.lu_slot_info    (lu_slot_info),
		.lu_pop          (lu_pop),
		.lu_pop_slot     (lu_pop_slot),
		.lu_exe_ready    (lu_exe_ready),
		.lu_exe_valid    (lu_exe_valid),
		.lu_exe_param    (lu_exe_param),
		.su_head_info    (su_head_info),
		.su_empty        (su_empty),
		.su_pop          (su_pop),
		.su_commit_ready (su_commit_ready),
		.su_exe_ready    (su_exe_ready),
		.su_exe_valid    (su_exe_valid),
		.su_exe_param    (su_exe_param),
		.xreg_value      (xreg_value),
		.wb_log          (wb_log)
	);

endmodule

//--- dv/lsu_issue_vectors.svh
`ifndef LSU_ISSUE_VECTORS_SVH
`define LSU_ISSUE_VECTORS_SVH

// One row per clock cycle
// Columns are dispatches, writeback, commit and ready levels, expected outputs
localparam int NUM_ROWS = 36;

// Inputs driven during the row's cycle
logic         row_lu_stb  [NUM_ROWS];
lu_info_t     row_lu_info [NUM_ROWS];
logic         row_su_stb  [NUM_ROWS];
su_info_t     row_su_info [NUM_ROWS];
logic         row_wb_stb  [NUM_ROWS];
reg_idx_t     row_wb_rd   [NUM_ROWS];
xdata_t       row_wb_data [NUM_ROWS];
logic         row_commit  [NUM_ROWS];
logic         row_lu_rdy  [NUM_ROWS];
logic         row_su_rdy  [NUM_ROWS];

// Outputs expected right after the edge that ends the row
logic         exp_lu_valid [NUM_ROWS];
lu_exeparam_t exp_lu_param [NUM_ROWS];
logic         exp_su_valid [NUM_ROWS];
su_exeparam_t exp_su_param [NUM_ROWS];
logic         exp_lu_full  [NUM_ROWS];
logic         exp_su_full  [NUM_ROWS];

// Row under construction with levels that carry over
int   fill;
logic cur_commit;
logic cur_lu_rdy;
logic cur_su_rdy;

// Load kinds 0..6 are lb lh lw ld lbu lhu lwu, store sizes 0..3 are sb sh sw sd
task automatic build_table();
	xdata_t imm [19];
	xdata_t v3;
	xdata_t v4;
	xdata_t v5;
	xdata_t v6;
	for (int i = 0; i < 19; i++) begin
		imm[i] = {$urandom(), $urandom()};
	end
	v3 = 64'h0000_0000_8000_0300;
	v4 = 64'hffff_ffff_0000_0400;
	v5 = 64'h0000_1234_0000_0500;
	v6 = 64'h7fff_0000_0000_0600;
	clear_table();
	fill = 0;
	set_levels(1'b0, 1'b1, 1'b1);
	// Idle after reset, then give x3 and x4 their values
	end_rows(1);
	add_wb(5'd3, v3);
	end_rows(1);
	add_wb(5'd4, v4);
	end_rows(1);
	// Load A is an lbu on x0 into x5
	add_load(4, 5'd5, 5'd0, imm[0]);
	end_rows(1);
	want_load(4, 5'd5, imm[0]);
	end_rows(2);
	// B waits on x5 and younger C overtakes it
	add_load(1, 5'd6, 5'd5, imm[1]);
	end_rows(1);
	add_load(2, 5'd7, 5'd3, imm[2]);
	end_rows(1);
	want_load(2, 5'd7, v3 + imm[2]);
	end_rows(1);
	add_wb(5'd5, v5);
	end_rows(1);
	want_load(1, 5'd6, v5 + imm[1]);
	end_rows(2);
	// Two stores held back by commit
	add_store(3, 5'd3, 5'd4, imm[3]);
	end_rows(1);
	add_store(2, 5'd4, 5'd3, imm[4]);
	end_rows(2);
	set_levels(1'b1, 1'b1, 1'b1);
	want_store(3, v3 + imm[3], v4);
	end_rows(1);
	want_store(2, v4 + imm[4], v3);
	end_rows(2);
	// D and S3 with E and S4 behind them
	add_load(3, 5'd8, 5'd4, imm[5]);
	add_store(0, 5'd0, 5'd4, imm[6]);
	end_rows(1);
	add_load(0, 5'd9, 5'd0, imm[7]);
	add_store(1, 5'd3, 5'd0, imm[8]);
	want_load(3, 5'd8, v4 + imm[5]);
	want_store(0, imm[6], v4);
	end_rows(1);
	// Consumers stall for two cycles
	set_levels(1'b1, 1'b0, 1'b0);
	want_load(3, 5'd8, v4 + imm[5]);
	want_store(0, imm[6], v4);
	end_rows(1);
	want_load(3, 5'd8, v4 + imm[5]);
	want_store(0, imm[6], v4);
	end_rows(1);
	set_levels(1'b1, 1'b1, 1'b1);
	want_load(0, 5'd9, imm[7]);
	want_store(1, v3 + imm[8], '0);
	end_rows(2);
	// Fill all four slots and the store queue behind busy x6
	add_load(5, 5'd11, 5'd6, imm[9]);
	add_store(3, 5'd6, 5'd3, imm[14]);
	end_rows(1);
	add_load(6, 5'd12, 5'd6, imm[10]);
	add_store(2, 5'd6, 5'd4, imm[15]);
	end_rows(1);
	add_load(0, 5'd13, 5'd6, imm[11]);
	add_store(1, 5'd6, 5'd5, imm[16]);
	end_rows(1);
	add_load(3, 5'd14, 5'd6, imm[12]);
	add_store(0, 5'd6, 5'd0, imm[17]);
	want_full(1'b1, 1'b1);
	end_rows(1);
	// Both are full so these two are dropped
	add_load(2, 5'd15, 5'd0, imm[13]);
	add_store(3, 5'd0, 5'd3, imm[18]);
	want_full(1'b1, 1'b1);
	end_rows(1);
	add_wb(5'd6, v6);
	want_full(1'b1, 1'b1);
	end_rows(1);
	want_load(5, 5'd11, v6 + imm[9]);
	want_store(3, v6 + imm[14], v3);
	end_rows(1);
	want_load(6, 5'd12, v6 + imm[10]);
	want_store(2, v6 + imm[15], v4);
	end_rows(1);
	want_load(0, 5'd13, v6 + imm[11]);
	want_store(1, v6 + imm[16], v5);
	end_rows(1);
	want_load(3, 5'd14, v6 + imm[12]);
	want_store(0, v6 + imm[17], '0);
	end_rows(1);
	// Nothing left
	end_rows(2);
endtask

`endif

//--- dv/lsu_issue_tb.sv
module lsu_issue_tb import core_pkg::*, lsu_pkg::*; ();

	localparam int PERIOD = 100;
	// Inputs change this long after the rising edge
	localparam int DRIVE_DELAY = 10;
	localparam int SEED = 69601;

	logic         CLK;
	logic         rst_n;
	logic         lu_dispatch_strobe;
	lu_info_t     lu_dispatch_info;
	logic         lu_buffer_full;
	logic         su_dispatch_strobe;
	su_info_t     su_dispatch_info;
	logic         su_fifo_full;
	logic         wb_strobe;
	reg_idx_t     wb_rd;
	xdata_t       wb_data;
	logic         su_commit_ready;
	logic         lu_exe_ready;
	logic         lu_exe_valid;
	lu_exeparam_t lu_exe_param;
	logic         su_exe_ready;
	logic         su_exe_valid;
	su_exeparam_t su_exe_param;

	`include "lsu_issue_vectors.svh"

	lsu_issue_top dut (.*);

	always #(PERIOD / 2) CLK = ~CLK;

	// Flags MSB first from lb down to lwu
	function automatic lu_info_t load_info(int kind, reg_idx_t rd, reg_idx_t rs1, xdata_t imm);
		logic [6:0] flags;
		flags = 7'b1000000 >> kind;
		return {flags, imm, rd, rs1};
	endfunction

	// Signed and unsigned kinds of one width share a function bit
	function automatic lu_exeparam_t issued_load(int kind, reg_idx_t rd, xdata_t addr);
		logic [3:0] fun;
		logic       uns;
		uns = (kind >= 4);
		fun = 4'b1000 >> (uns ? kind - 4 : kind);
		return {fun, rd, addr, uns};
	endfunction

	function automatic su_info_t store_info(int size, reg_idx_t rs1, reg_idx_t rs2, xdata_t imm);
		logic [3:0] flags;
		flags = 4'b1000 >> size;
		return {flags, imm, rs1, rs2};
	endfunction

	function automatic su_exeparam_t issued_store(int size, xdata_t addr, xdata_t data);
		logic [3:0] flags;
		flags = 4'b1000 >> size;
		return {flags, addr, data};
	endfunction

	// Table helpers act on row fill
	task automatic add_load(int kind, reg_idx_t rd, reg_idx_t rs1, xdata_t imm);
		row_lu_stb[fill] = 1'b1;
		row_lu_info[fill] = load_info(kind, rd, rs1, imm);
	endtask

	task automatic add_store(int size, reg_idx_t rs1, reg_idx_t rs2, xdata_t imm);
		row_su_stb[fill] = 1'b1;
		row_su_info[fill] = store_info(size, rs1, rs2, imm);
	endtask

	task automatic add_wb(reg_idx_t rd, xdata_t data);
		row_wb_stb[fill] = 1'b1;
		row_wb_rd[fill] = rd;
		row_wb_data[fill] = data;
	endtask

	task automatic want_load(int kind, reg_idx_t rd, xdata_t addr);
		exp_lu_valid[fill] = 1'b1;
		exp_lu_param[fill] = issued_load(kind, rd, addr);
	endtask

	task automatic want_store(int size, xdata_t addr, xdata_t data);
		exp_su_valid[fill] = 1'b1;
		exp_su_param[fill] = issued_store(size, addr, data);
	endtask

	task automatic want_full(logic lu_full, logic su_full);
		exp_lu_full[fill] = lu_full;
		exp_su_full[fill] = su_full;
	endtask

	task automatic set_levels(logic commit, logic lu_rdy, logic su_rdy);
		cur_commit = commit;
		cur_lu_rdy = lu_rdy;
		cur_su_rdy = su_rdy;
	endtask

	// Close the current row plus n-1 idle rows after it
	task automatic end_rows(int n);
		for (int i = 0; i < n; i++) begin
			row_commit[fill] = cur_commit;
			row_lu_rdy[fill] = cur_lu_rdy;
			row_su_rdy[fill] = cur_su_rdy;
			fill++;
		end
	endtask

	task automatic clear_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			row_lu_stb[r] = 1'b0;
			row_lu_info[r] = '0;
			row_su_stb[r] = 1'b0;
			row_su_info[r] = '0;
			row_wb_stb[r] = 1'b0;
			row_wb_rd[r] = '0;
			row_wb_data[r] = '0;
			exp_lu_valid[r] = 1'b0;
			exp_lu_param[r] = '0;
			exp_su_valid[r] = 1'b0;
			exp_su_param[r] = '0;
			exp_lu_full[r] = 1'b0;
			exp_su_full[r] = 1'b0;
		end
	endtask

	task automatic apply_row(int r);
		lu_dispatch_strobe = row_lu_stb[r];
		lu_dispatch_info = row_lu_info[r];
		su_dispatch_strobe = row_su_stb[r];
		su_dispatch_info = row_su_info[r];
		wb_strobe = row_wb_stb[r];
		wb_rd = row_wb_rd[r];
		wb_data = row_wb_data[r];
		su_commit_ready = row_commit[r];
		lu_exe_ready = row_lu_rdy[r];
		su_exe_ready = row_su_rdy[r];
	endtask

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	// Param only matters while valid
	task automatic check_lu_exe(int row, logic exp_valid, lu_exeparam_t exp_param);
		if (lu_exe_valid !== exp_valid) begin
			fail_run($sformatf("mismatch at %0t: row %0d lu_exe_valid %b, expected %b",
				$time, row, lu_exe_valid, exp_valid));
		end else if (exp_valid && lu_exe_param !== exp_param) begin
			fail_run($sformatf("mismatch at %0t: row %0d lu_exe_param %h, expected %h",
				$time, row, lu_exe_param, exp_param));
		end
	endtask

	task automatic check_su_exe(int row, logic exp_valid, su_exeparam_t exp_param);
		if (su_exe_valid !== exp_valid) begin
			fail_run($sformatf("mismatch at %0t: row %0d su_exe_valid %b, expected %b",
				$time, row, su_exe_valid, exp_valid));
		end else if (exp_valid && su_exe_param !== exp_param) begin
			fail_run($sformatf("mismatch at %0t: row %0d su_exe_param %h, expected %h",
				$time, row, su_exe_param, exp_param));
		end
	endtask

	// Dispatch-side full flags
	task automatic check_full(int row, logic exp_lu, logic exp_su);
		if (lu_buffer_full !== exp_lu) begin
			fail_run($sformatf("mismatch at %0t: row %0d lu_buffer_full %b, expected %b",
				$time, row, lu_buffer_full, exp_lu));
		end else if (su_fifo_full !== exp_su) begin
			fail_run($sformatf("mismatch at %0t: row %0d su_fifo_full %b, expected %b",
				$time, row, su_fifo_full, exp_su));
		end
	endtask

	// Watchdog sized from the table length plus slack for reset
	initial begin
		#((NUM_ROWS + 20) * PERIOD);
		fail_run("timeout: the vector table did not finish in time");
	end

	initial begin
		void'($urandom(SEED));
		CLK = 1'b0;
		rst_n = 1'b0;
		lu_dispatch_strobe = 1'b0;
		lu_dispatch_info = '0;
		su_dispatch_strobe = 1'b0;
		su_dispatch_info = '0;
		wb_strobe = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		su_commit_ready = 1'b0;
		lu_exe_ready = 1'b0;
		su_exe_ready = 1'b0;
		build_table();
		repeat (2) @(posedge CLK);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		// Drive a row and check what the next edge registered
		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(r);
			@(posedge CLK);
			#DRIVE_DELAY;
			check_lu_exe(r, exp_lu_valid[r], exp_lu_param[r]);
			check_su_exe(r, exp_su_valid[r], exp_su_param[r]);
			check_full(r, exp_lu_full[r], exp_su_full[r]);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+dv
source/core_pkg.sv
source/lsu_pkg.sv
source/first_zero_finder.sv
source/regfile_wblog.sv
source/lu_issue_buffer.sv
source/su_issue_fifo.sv
source/lsu_issue.sv
source/lsu_issue_top.sv
dv/lsu_issue_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run, pass only if the testbench reports it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module lsu_issue_tb -o lsu_issue_sim \
	&& ./obj_dir/lsu_issue_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
